//--- median_pkg.sv
`default_nettype none

package median_pkg;

  // window geometry
  localparam int PIXEL_W = 8;
  localparam int WIN_N   = 7;

  // pixels left after pruning the sorted window
  localparam int CAND_N = 25;

  // pipeline depths in clock cycles
  localparam int SORT_LAT   = 7;
  localparam int MEDIAN_LAT = 18;

  typedef logic [PIXEL_W-1:0] pixel_t;

  // index 0 is column 0, or the smallest value once sorted
  typedef pixel_t [WIN_N-1:0] row_t;

  // row r, column c holds input pixel r*7+c
  typedef row_t [WIN_N-1:0] window_t;

  typedef pixel_t [CAND_N-1:0] cand_t;

  typedef struct packed {
    logic valid;
    row_t data;
  } row_beat_t;

  typedef struct packed {
    logic    valid;
    window_t data;
  } win_beat_t;

  typedef struct packed {
    logic  valid;
    cand_t data;
  } cand_beat_t;

endpackage

`default_nettype wire

//--- window_capture.sv
`timescale 1ns/1ps
`default_nettype none

module window_capture (
  input  logic                  clk,
  input  logic                  rst_n,
  input  median_pkg::win_beat_t beat_i,
  output median_pkg::row_beat_t rows_o [median_pkg::WIN_N]
);

  import median_pkg::*;

  win_beat_t beat_q;

  // input register bank, one full window per cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else begin
      beat_q <= beat_i;
    end
  end

  // split into rows, every row carries the same valid
  always_comb begin
    for (int r = 0; r < WIN_N; r++) begin
      rows_o[r].valid = beat_q.valid;
      rows_o[r].data  = beat_q.data[r];
    end
  end

endmodule

`default_nettype wire

//--- sort7_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module sort7_pipe (
  input  logic                  clk,
  input  logic                  rst_n,
  input  median_pkg::row_beat_t beat_i,
  output median_pkg::row_beat_t beat_o
);

  import median_pkg::*;

  row_t                data_q [SORT_LAT];
  logic [SORT_LAT-1:0] vld_q;

  // one compare-exchange layer, even pairs or odd pairs
  function automatic row_t exch_layer(input row_t r, input int phase);
    row_t res;
    res = r;
    for (int j = 0; j < WIN_N - 1; j++) begin
      if ((j % 2) == phase) begin
        if (r[j] > r[j+1]) begin
          res[j]   = r[j+1];
          res[j+1] = r[j];
        end
      end
    end
    return res;
  endfunction

  function automatic logic is_ascending(input row_t r);
    logic ok;
    ok = 1'b1;
    for (int j = 0; j < WIN_N - 1; j++) begin
      if (r[j] > r[j+1]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // seven layers of odd-even transposition, one per register stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < SORT_LAT; s++) begin
        data_q[s] <= '0;
      end
      vld_q <= '0;
    end else begin
      data_q[0] <= exch_layer(beat_i.data, 0);
      for (int s = 1; s < SORT_LAT; s++) begin
        data_q[s] <= exch_layer(data_q[s-1], s % 2);
      end
      // valid follows its data through every stage
      vld_q <= {vld_q[SORT_LAT-2:0], beat_i.valid};
    end
  end

  assign beat_o = '{valid: vld_q[SORT_LAT-1], data: data_q[SORT_LAT-1]};

  // the full network must leave the row in ascending order
  a_sorted_out: assert property (
    @(posedge clk) disable iff (!rst_n)
    beat_o.valid |-> is_ascending(beat_o.data)
  ) else $error("sort7_pipe output not in ascending order");

endmodule

`default_nettype wire

//--- column_stage.sv
`timescale 1ns/1ps
`default_nettype none

module column_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  median_pkg::row_beat_t  rows_i [median_pkg::WIN_N],
  output median_pkg::cand_beat_t cand_o
);

  import median_pkg::*;

  row_beat_t  col_in  [WIN_N];
  row_beat_t  col_out [WIN_N];
  pixel_t     ul_max;
  pixel_t     lr_min;
  cand_t      cand_d;
  cand_beat_t cand_q;

  function automatic pixel_t max3(input pixel_t a, input pixel_t b, input pixel_t c);
    pixel_t m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
  endfunction

  function automatic pixel_t min3(input pixel_t a, input pixel_t b, input pixel_t c);
    pixel_t m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  // column k of the transpose gathers rank k of every sorted row
  // rows run in lockstep so row 0 valid stands for the rest
  always_comb begin
    for (int k = 0; k < WIN_N; k++) begin
      col_in[k].valid = rows_i[0].valid;
      for (int r = 0; r < WIN_N; r++) begin
        col_in[k].data[r] = rows_i[r].data[k];
      end
    end
  end

  for (genvar k = 0; k < WIN_N; k++) begin : g_col_sort
    sort7_pipe u_sort (
      .clk    (clk),
      .rst_n  (rst_n),
      .beat_i (col_in[k]),
      .beat_o (col_out[k])
    );
  end

  // after both sorts entry (i,k) is col_out[k].data[i]
  // corner triples (2,2) (1,3) (0,4) and (6,2) (5,3) (4,4)
  assign ul_max = max3(col_out[2].data[2], col_out[3].data[1], col_out[4].data[0]);
  assign lr_min = min3(col_out[2].data[6], col_out[3].data[5], col_out[4].data[4]);

  // band 4 <= i+k <= 8 with each corner triple collapsed to one value
  always_comb begin
    cand_d[0]  = col_out[5].data[0];
    cand_d[1]  = col_out[6].data[0];
    cand_d[2]  = col_out[4].data[1];
    cand_d[3]  = col_out[5].data[1];
    cand_d[4]  = col_out[6].data[1];
    cand_d[5]  = ul_max;
    cand_d[6]  = col_out[3].data[2];
    cand_d[7]  = col_out[4].data[2];
    cand_d[8]  = col_out[5].data[2];
    cand_d[9]  = col_out[6].data[2];
    cand_d[10] = col_out[1].data[3];
    cand_d[11] = col_out[2].data[3];
    cand_d[12] = col_out[3].data[3];
    cand_d[13] = col_out[4].data[3];
    cand_d[14] = col_out[5].data[3];
    cand_d[15] = col_out[0].data[4];
    cand_d[16] = col_out[1].data[4];
    cand_d[17] = col_out[2].data[4];
    cand_d[18] = col_out[3].data[4];
    cand_d[19] = lr_min;
    cand_d[20] = col_out[0].data[5];
    cand_d[21] = col_out[1].data[5];
    cand_d[22] = col_out[2].data[5];
    cand_d[23] = col_out[0].data[6];
    cand_d[24] = col_out[1].data[6];
  end

  // pruning register adds the eighth cycle of this stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cand_q <= '0;
    end else begin
      cand_q.valid <= col_out[0].valid;
      cand_q.data  <= cand_d;
    end
  end

  assign cand_o = cand_q;

endmodule

`default_nettype wire

//--- rank_select.sv
`timescale 1ns/1ps
`default_nettype none

module rank_select (
  input  logic                   clk,
  input  logic                   rst_n,
  input  median_pkg::cand_beat_t cand_i,
  output median_pkg::pixel_t     median_o,
  output logic                   valid_o
);

  import median_pkg::*;

  localparam int RANK_W   = $clog2(CAND_N);
  localparam int MID_RANK = CAND_N / 2;

  typedef logic [RANK_W-1:0] rank_t;

  rank_t  rank_d [CAND_N];
  rank_t  rank_q [CAND_N];
  cand_t  cand_q;
  logic   vld_q;
  pixel_t median_d;
  pixel_t median_q;
  logic   valid_q;

  // rank = number of smaller candidates
  // ties broken by index so every rank is unique
  always_comb begin
    for (int j = 0; j < CAND_N; j++) begin
      rank_d[j] = '0;
      for (int m = 0; m < CAND_N; m++) begin
        if ((cand_i.data[m] < cand_i.data[j]) ||
            ((cand_i.data[m] == cand_i.data[j]) && (m < j))) begin
          rank_d[j] = rank_d[j] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int j = 0; j < CAND_N; j++) begin
        rank_q[j] <= '0;
      end
      cand_q <= '0;
      vld_q  <= 1'b0;
    end else begin
      rank_q <= rank_d;
      cand_q <= cand_i.data;
      vld_q  <= cand_i.valid;
    end
  end

  // exactly one candidate holds the middle rank, so OR them together
  always_comb begin
    median_d = '0;
    for (int j = 0; j < CAND_N; j++) begin
      if (rank_q[j] == rank_t'(MID_RANK)) begin
        median_d = median_d | cand_q[j];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      median_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      median_q <= median_d;
      valid_q  <= vld_q;
    end
  end

  assign median_o = median_q;
  assign valid_o  = valid_q;

  // nothing can reach the output before a window has crossed the whole pipe
  a_no_early_valid: assert property (
    @(posedge clk) $rose(rst_n) |-> !valid_o [*MEDIAN_LAT]
  ) else $error("valid_o high before pipeline latency elapsed");

endmodule

`default_nettype wire

//--- median7x7_top.sv
`timescale 1ns/1ps
`default_nettype none

module median7x7_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  median_pkg::win_beat_t beat_i,
  output median_pkg::pixel_t    median_o,
  output logic                  valid_o
);

  import median_pkg::*;

  row_beat_t  row_raw [WIN_N];
  row_beat_t  row_srt [WIN_N];
  cand_beat_t cand;

  // 1 cycle
  window_capture u_capture (
    .clk    (clk),
    .rst_n  (rst_n),
    .beat_i (beat_i),
    .rows_o (row_raw)
  );

  // row sort, 7 cycles
  for (genvar r = 0; r < WIN_N; r++) begin : g_row_sort
    sort7_pipe u_sort (
      .clk    (clk),
      .rst_n  (rst_n),
      .beat_i (row_raw[r]),
      .beat_o (row_srt[r])
    );
  end

  // column sort and pruning, 8 cycles
  column_stage u_columns (
    .clk    (clk),
    .rst_n  (rst_n),
    .rows_i (row_srt),
    .cand_o (cand)
  );

  // 2 cycles
  rank_select u_select (
    .clk      (clk),
    .rst_n    (rst_n),
    .cand_i   (cand),
    .median_o (median_o),
    .valid_o  (valid_o)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset low for the first 5 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_median7x7.sv
`timescale 1ns/1ps
`default_nettype none

module tb_median7x7;

  import median_pkg::*;

  // room for about 400 windows plus idle gaps and drains
  localparam int TIMEOUT_CYC = 2000;
  localparam int N_RANDOM    = 300;
  localparam int N_GAPPED    = 60;

  logic      clk;
  logic      rst_n;
  win_beat_t beat;
  pixel_t    median;
  logic      median_vld;

  int     cyc = 0;
  integer seed = 32'h8cd6_a902;
  int     in_cnt = 0;
  int     out_cnt = 0;
  int     err_cnt = 0;
  int     cnt_err = 0;
  int     tests_ok = 0;
  int     tests_bad = 0;
  string  test_name = "reset";

  // counter values when the current test started
  int     in_start = 0;
  int     out_start = 0;
  int     err_start = 0;
  int     cnt_start = 0;

  // expected medians in arrival order
  pixel_t exp_q [$];
  int     cyc_q [$];
  string  name_q [$];

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  median7x7_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .beat_i   (beat),
    .median_o (median),
    .valid_o  (median_vld)
  );

  // median of 49 is index 24 of the sorted pixels
  function automatic pixel_t ref_median(input window_t w);
    pixel_t v [49];
    pixel_t t;
    for (int r = 0; r < 7; r++) begin
      for (int c = 0; c < 7; c++) begin
        v[r*7+c] = w[r][c];
      end
    end
    for (int i = 0; i < 48; i++) begin
      for (int j = 0; j < 48 - i; j++) begin
        if (v[j] > v[j+1]) begin
          t      = v[j];
          v[j]   = v[j+1];
          v[j+1] = t;
        end
      end
    end
    return v[24];
  endfunction

  function automatic window_t random_window();
    window_t w;
    for (int r = 0; r < 7; r++) begin
      for (int c = 0; c < 7; c++) begin
        w[r][c] = pixel_t'($random(seed));
      end
    end
    return w;
  endfunction

  // cycle counter and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test failed");
      $finish;
    end
  end

  // record each window the DUT samples at the next rising edge
  always @(negedge clk) begin
    if (rst_n && beat.valid) begin
      exp_q.push_back(ref_median(beat.data));
      cyc_q.push_back(cyc);
      name_q.push_back(test_name);
      in_cnt++;
    end
  end

  always @(negedge clk) begin : compare_out
    pixel_t exp_v;
    int     exp_c;
    string  nm;
    if (rst_n && median_vld) begin
      out_cnt++;
      if (exp_q.size() == 0) begin
        $display("valid_o went high at cycle %0d with no window in flight", cyc);
        err_cnt++;
      end else begin
        exp_v = exp_q.pop_front();
        exp_c = cyc_q.pop_front();
        nm    = name_q.pop_front();
        assert (median == exp_v) else begin
          $display("[FAIL] %s: median expected %0d, actual %0d", nm, exp_v, median);
          err_cnt++;
        end
        assert (cyc - exp_c == MEDIAN_LAT) else begin
          $display("[FAIL] %s: latency expected %0d, actual %0d", nm, MEDIAN_LAT,
                   cyc - exp_c);
          err_cnt++;
        end
      end
    end
  end

  task automatic send_window(input window_t w);
    @(posedge clk);
    beat.valid <= 1'b1;
    beat.data  <= w;
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      beat.valid <= 1'b0;
    end
  endtask

  task automatic open_test(input string name);
    test_name = name;
    in_start  = in_cnt;
    out_start = out_cnt;
    err_start = err_cnt;
    cnt_start = cnt_err;
  endtask

  // flush, wait for every output, then report
  task automatic close_test();
    drive_idle(1);
    while (out_cnt < in_cnt) @(posedge clk);
    drive_idle(2);
    assert (out_cnt - out_start == in_cnt - in_start) else begin
      $display("[FAIL] %s: outputs expected %0d, actual %0d", test_name,
               in_cnt - in_start, out_cnt - out_start);
      cnt_err++;
    end
    if (err_cnt == err_start && cnt_err == cnt_start) begin
      tests_ok++;
      $display("test %s: %0d windows, ok", test_name, in_cnt - in_start);
    end else begin
      tests_bad++;
      $display("test %s: %0d windows, errors found", test_name, in_cnt - in_start);
    end
  endtask

  initial begin
    int      gap;
    window_t w;
    pixel_t  levels [6];
    levels = '{8'd0, 8'd255, 8'd1, 8'd127, 8'd128, 8'd200};
    beat <= '0;
    wait (rst_n);

    // no input means no output
    open_test("idle");
    drive_idle(30);
    close_test();

    // constant windows
    open_test("constant");
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 49; p++) begin
        w[p/7][p%7] = levels[k];
      end
      send_window(w);
    end
    close_test();

    // structured windows
    open_test("ascending");
    for (int p = 0; p < 49; p++) begin
      w[p/7][p%7] = pixel_t'(p * 5);
    end
    send_window(w);
    close_test();

    open_test("descending");
    for (int p = 0; p < 49; p++) begin
      w[p/7][p%7] = pixel_t'(255 - p * 5);
    end
    send_window(w);
    close_test();

    // 3*p mod 49 is a permutation so exactly 25 pixels land below 25
    open_test("black_white");
    for (int p = 0; p < 49; p++) begin
      w[p/7][p%7] = ((p * 3) % 49 < 25) ? 8'd255 : 8'd0;
    end
    send_window(w);
    for (int p = 0; p < 49; p++) begin
      w[p/7][p%7] = ((p * 3) % 49 < 25) ? 8'd0 : 8'd255;
    end
    send_window(w);
    close_test();

    open_test("duplicates");
    for (int k = 0; k < 8; k++) begin
      for (int p = 0; p < 49; p++) begin
        w[p/7][p%7] = pixel_t'(($random(seed) & 3) * 60);
      end
      send_window(w);
    end
    close_test();

    // one window per cycle
    open_test("random_back_to_back");
    for (int k = 0; k < N_RANDOM; k++) begin
      send_window(random_window());
    end
    close_test();

    // gaps of 0 to 3 idle cycles
    open_test("random_gaps");
    for (int k = 0; k < N_GAPPED; k++) begin
      gap = $random(seed) & 3;
      drive_idle(gap);
      send_window(random_window());
    end
    close_test();

    $display("tests: %0d ok, %0d with errors; windows: %0d in, %0d out; errors: %0d",
             tests_ok, tests_bad, in_cnt, out_cnt, err_cnt + cnt_err);
    if (tests_bad == 0 && err_cnt == 0 && cnt_err == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
median_pkg.sv
window_capture.sv
sort7_pipe.sv
column_stage.sv
rank_select.sv
median7x7_top.sv
tb_clk_gen.sv
tb_median7x7.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the 7x7 median testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f src.f --top-module tb_median7x7 -o sim_median \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_median > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
